// File: Makefile
# Verilator build and run for the register file block

VERILATOR  := verilator
TOP        := tb_rf_top
FILE_LIST  := src.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert
SIM_ARGS   := +verilator+error+limit+1000
LOG        := sim.log
PASS_MSG   := *** TEST PASSED ***

SIM_BIN    := $(BUILD_DIR)/V$(TOP)
SOURCES    := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP)

run: $(SIM_BIN)
	-./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rf_clock_ctrl.sv
/*
  Sleep and clock-enable control. Captures fetch enable once, registers the
  busy flag and forms the wake condition. Produces an enable in place of a
  gated clock; core_sleep_o is its inverse.
*/

`timescale 1ns/10ps

module rf_clock_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Wake sources
  input  logic                          fetch_enable_i,
  input  logic                          core_busy_i,
  input  logic                          debug_req_i,
  input  logic                          irq_pending_i,
  input  logic                          irq_nm_i,
  input  logic [rf_pkg::NumIrqFast-1:0] irq_fast_i,

  // Enable towards the storage and sleep status
  output logic                          clock_en_o,
  output logic                          core_sleep_o
);

  logic fetch_enable_q;
  logic core_busy_q;
  logic irq_any;
  logic wake;

  //////////////////////////////////////////////////
  // Sticky fetch enable
  //////////////////////////////////////////////////

  // Set once and held until the next reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_enable_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_enable_q <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Busy flag
  //////////////////////////////////////////////////

  // Busy acts on wake one cycle late
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  //////////////////////////////////////////////////
  // Wake condition
  //////////////////////////////////////////////////

  // Debug and interrupts wake in the same cycle
  assign irq_any = irq_pending_i | irq_nm_i | (|irq_fast_i);

  assign wake = fetch_enable_q & (core_busy_q | debug_req_i | irq_any);

  assign clock_en_o   = wake;
  assign core_sleep_o = ~wake;

endmodule

// File: rf_pkg.sv
/*
  Shared widths, counts and types for the register file block.
  Modules refer to these by scoped names, e.g. rf_pkg::reg_data_t.
*/

package rf_pkg;

  //////////////////////////////////////////////////
  // Register file geometry
  //////////////////////////////////////////////////

  // Width of one register and of the read and write data
  parameter int unsigned DataWidth = 32;

  // Address width for the full RV32I register set
  parameter int unsigned MaxRegAddrWidth = 5;

  // Full register count addressed by MaxRegAddrWidth
  parameter int unsigned MaxNumRegs = 2 ** MaxRegAddrWidth;

  //////////////////////////////////////////////////
  // Interrupts
  //////////////////////////////////////////////////

  // Fast local interrupt lines
  parameter int unsigned NumIrqFast = 15;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // Register index on the read and write ports
  typedef logic [MaxRegAddrWidth-1:0] reg_addr_t;

  // Contents of one register
  typedef logic [DataWidth-1:0] reg_data_t;

endpackage

// File: rf_register_file.sv
/*
  Flip-flop register file, two combinational read ports and one write port.
  Register zero is hardwired to zero. With RV32E only x0 to x15 exist, and
  writes are accepted only while clock_en_i is high.
*/

`timescale 1ns/10ps

module rf_register_file #(
  parameter bit RV32E = 1'b0
) (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Enable from the sleep control
  input  logic              clock_en_i,

  // Write port, single-cycle strobe
  input  logic              we_i,
  input  rf_pkg::reg_addr_t waddr_i,
  input  rf_pkg::reg_data_t wdata_i,

  // Read port A
  input  rf_pkg::reg_addr_t raddr_a_i,
  output rf_pkg::reg_data_t rdata_a_o,

  // Read port B
  input  rf_pkg::reg_addr_t raddr_b_i,
  output rf_pkg::reg_data_t rdata_b_o
);

  localparam int unsigned NumRegs   = RV32E ? 16 : rf_pkg::MaxNumRegs;
  localparam int unsigned AddrWidth = RV32E ? 4 : rf_pkg::MaxRegAddrWidth;

  rf_pkg::reg_data_t    rf_reg [NumRegs];
  logic [NumRegs-1:1]   we_dec;
  logic                 write_valid;
  logic                 raddr_a_valid;
  logic                 raddr_b_valid;

  //////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////

  // No register changes while asleep
  assign write_valid = we_i & clock_en_i;

  // Address compare on the full width drops out-of-range writes
  always_comb begin
    for (int unsigned i = 1; i < NumRegs; i++) begin
      we_dec[i] = write_valid & (waddr_i == rf_pkg::reg_addr_t'(i));
    end
  end

  //////////////////////////////////////////////////
  // Register array
  //////////////////////////////////////////////////

  for (genvar i = 1; i < NumRegs; i++) begin : gen_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_reg[i] <= '0;
      end else if (we_dec[i]) begin
        rf_reg[i] <= wdata_i;
      end
    end
  end

  // x0 reads as zero whatever is written to it
  assign rf_reg[0] = '0;

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////

  // Addresses beyond the implemented set read as zero
  assign raddr_a_valid = (raddr_a_i < rf_pkg::reg_addr_t'(NumRegs - 1)) |
                         (raddr_a_i == rf_pkg::reg_addr_t'(NumRegs - 1));
  assign raddr_b_valid = (raddr_b_i < rf_pkg::reg_addr_t'(NumRegs - 1)) |
                         (raddr_b_i == rf_pkg::reg_addr_t'(NumRegs - 1));

  always_comb begin
    if (raddr_a_valid) begin
      rdata_a_o = rf_reg[raddr_a_i[AddrWidth-1:0]];
    end else begin
      rdata_a_o = '0;
    end
  end

  always_comb begin
    if (raddr_b_valid) begin
      rdata_b_o = rf_reg[raddr_b_i[AddrWidth-1:0]];
    end else begin
      rdata_b_o = '0;
    end
  end

endmodule

// File: rf_top.sv
/*
  Top level of the register file block. Joins the sleep control and the
  register file and passes RV32E down. Writes land only while awake.
*/

`timescale 1ns/10ps

module rf_top #(
  parameter bit RV32E = 1'b0
) (
  // Clock and reset
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Control and wake sources
  input  logic                          fetch_enable_i,
  input  logic                          core_busy_i,
  input  logic                          debug_req_i,
  input  logic                          irq_pending_i,
  input  logic                          irq_nm_i,
  input  logic [rf_pkg::NumIrqFast-1:0] irq_fast_i,

  // Write port
  input  logic                          we_i,
  input  rf_pkg::reg_addr_t             waddr_i,
  input  rf_pkg::reg_data_t             wdata_i,

  // Read ports
  input  rf_pkg::reg_addr_t             raddr_a_i,
  output rf_pkg::reg_data_t             rdata_a_o,
  input  rf_pkg::reg_addr_t             raddr_b_i,
  output rf_pkg::reg_data_t             rdata_b_o,

  // Status
  output logic                          core_sleep_o
);

  // Stands in for the gated core clock
  logic clock_en;

  //////////////////////////////////////////////////
  // Sleep control
  //////////////////////////////////////////////////

  rf_clock_ctrl u_clock_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .fetch_enable_i ( fetch_enable_i ),
    .core_busy_i    ( core_busy_i    ),
    .debug_req_i    ( debug_req_i    ),
    .irq_pending_i  ( irq_pending_i  ),
    .irq_nm_i       ( irq_nm_i       ),
    .irq_fast_i     ( irq_fast_i     ),
    .clock_en_o     ( clock_en       ),
    .core_sleep_o   ( core_sleep_o   )
  );

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////

  rf_register_file #(
    .RV32E ( RV32E )
  ) u_register_file (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .clock_en_i ( clock_en  ),
    .we_i       ( we_i      ),
    .waddr_i    ( waddr_i   ),
    .wdata_i    ( wdata_i   ),
    .raddr_a_i  ( raddr_a_i ),
    .rdata_a_o  ( rdata_a_o ),
    .raddr_b_i  ( raddr_b_i ),
    .rdata_b_o  ( rdata_b_o )
  );

endmodule

// File: rf_top_assert.sv
/*
  Checker bound into rf_top. Keeps its own copy of the register contents and
  of the sleep rule, and checks core_sleep_o and both read ports every cycle.
*/

`timescale 1ns/10ps

module rf_top_assert #(
  parameter bit RV32E = 1'b0
) (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          fetch_enable_i,
  input logic                          core_busy_i,
  input logic                          debug_req_i,
  input logic                          irq_pending_i,
  input logic                          irq_nm_i,
  input logic [rf_pkg::NumIrqFast-1:0] irq_fast_i,
  input logic                          we_i,
  input rf_pkg::reg_addr_t             waddr_i,
  input rf_pkg::reg_data_t             wdata_i,
  input rf_pkg::reg_addr_t             raddr_a_i,
  input rf_pkg::reg_data_t             rdata_a_o,
  input rf_pkg::reg_addr_t             raddr_b_i,
  input rf_pkg::reg_data_t             rdata_b_o,
  input logic                          core_sleep_o
);

  localparam int unsigned NumModelRegs = RV32E ? 16 : rf_pkg::MaxNumRegs;

  rf_pkg::reg_data_t model_regs [rf_pkg::MaxNumRegs];
  rf_pkg::reg_data_t expected_a;
  rf_pkg::reg_data_t expected_b;
  logic              fetch_enable_q;
  logic              busy_q;
  logic              wake;
  logic              assert_failed = 1'b0;

  // x0 and unimplemented registers read as zero
  function automatic rf_pkg::reg_data_t model_read(rf_pkg::reg_addr_t addr);
    rf_pkg::reg_data_t value;
    value = '0;
    if (addr != '0 && 32'(addr) < NumModelRegs) begin
      value = model_regs[addr];
    end
    return value;
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  assign wake = fetch_enable_q &
                (busy_q | debug_req_i | irq_pending_i | irq_nm_i | (|irq_fast_i));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_enable_q <= 1'b0;
      busy_q         <= 1'b0;
      model_regs     <= '{default: '0};
    end else begin
      if (fetch_enable_i) begin
        fetch_enable_q <= 1'b1;
      end
      busy_q <= core_busy_i;
      if (we_i && wake && waddr_i != '0 && 32'(waddr_i) < NumModelRegs) begin
        model_regs[waddr_i] <= wdata_i;
      end
    end
  end

  always_comb begin
    expected_a = model_read(raddr_a_i);
    expected_b = model_read(raddr_b_i);
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_asleep_before_fetch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !fetch_enable_q |-> core_sleep_o)
    else begin
      assert_failed = 1'b1;
      $error("Mismatch core_sleep_o: got 0x%h expected 0x1", $sampled(core_sleep_o));
    end

  a_sleep_rule: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_enable_q |-> (core_sleep_o == !wake))
    else begin
      assert_failed = 1'b1;
      $error("Mismatch core_sleep_o: got 0x%h expected 0x%h",
             $sampled(core_sleep_o), !$sampled(wake));
    end

  a_read_port_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rdata_a_o == expected_a)
    else begin
      assert_failed = 1'b1;
      $error("Mismatch rdata_a_o at addr 0x%h: got 0x%h expected 0x%h",
             $sampled(raddr_a_i), $sampled(rdata_a_o), $sampled(expected_a));
    end

  a_read_port_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rdata_b_o == expected_b)
    else begin
      assert_failed = 1'b1;
      $error("Mismatch rdata_b_o at addr 0x%h: got 0x%h expected 0x%h",
             $sampled(raddr_b_i), $sampled(rdata_b_o), $sampled(expected_b));
    end

  // x0 is zero on both ports regardless of earlier writes
  a_zero_reg: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((raddr_a_i == '0) |-> (rdata_a_o == '0)) and ((raddr_b_i == '0) |-> (rdata_b_o == '0)))
    else begin
      assert_failed = 1'b1;
      $error("Mismatch x0 read: rdata_a_o 0x%h rdata_b_o 0x%h expected 0x0",
             $sampled(rdata_a_o), $sampled(rdata_b_o));
    end

endmodule

bind rf_top rf_top_assert #(
  .RV32E ( RV32E )
) u_assert (
  .clk_i          ( clk_i          ),
  .rst_ni         ( rst_ni         ),
  .fetch_enable_i ( fetch_enable_i ),
  .core_busy_i    ( core_busy_i    ),
  .debug_req_i    ( debug_req_i    ),
  .irq_pending_i  ( irq_pending_i  ),
  .irq_nm_i       ( irq_nm_i       ),
  .irq_fast_i     ( irq_fast_i     ),
  .we_i           ( we_i           ),
  .waddr_i        ( waddr_i        ),
  .wdata_i        ( wdata_i        ),
  .raddr_a_i      ( raddr_a_i      ),
  .rdata_a_o      ( rdata_a_o      ),
  .raddr_b_i      ( raddr_b_i      ),
  .rdata_b_o      ( rdata_b_o      ),
  .core_sleep_o   ( core_sleep_o   )
);

// File: src.f
rf_pkg.sv
rf_clock_ctrl.sv
rf_register_file.sv
rf_top.sv
rf_top_assert.sv
tb_rf_top.sv

// File: tb_rf_top.sv
/*
  Testbench for rf_top. Drives sleep, wake and register traffic with seeded
  random data; the bound checker does the comparing and this module reports.
*/

`timescale 1ns/10ps

module tb_rf_top;

  localparam int unsigned ResetCycles     = 2;
  localparam int unsigned SleepWrites     = 12;
  localparam int unsigned ScalarHigh      = 4;
  localparam int unsigned FastHigh        = 2;
  localparam int unsigned WakeCycles      = 4 * (ScalarHigh + 1) +
                                            rf_pkg::NumIrqFast * (FastHigh + 1);
  localparam int unsigned RandomCycles    = 300;
  localparam int unsigned LateSleepWrites = 12;
  localparam int unsigned PlannedCycles   = ResetCycles + 4 * SleepWrites + WakeCycles +
                                            RandomCycles + 2 * LateSleepWrites + 8;
  localparam int unsigned TimeoutCycles   = 2 * PlannedCycles;

  logic                          clk = 1'b0;
  logic                          rst_n;
  logic                          fetch_enable;
  logic                          core_busy;
  logic                          debug_req;
  logic                          irq_pending;
  logic                          irq_nm;
  logic [rf_pkg::NumIrqFast-1:0] irq_fast;
  logic                          we;
  rf_pkg::reg_addr_t             waddr;
  rf_pkg::reg_data_t             wdata;
  rf_pkg::reg_addr_t             raddr_a;
  rf_pkg::reg_data_t             rdata_a;
  rf_pkg::reg_addr_t             raddr_b;
  rf_pkg::reg_data_t             rdata_b;
  logic                          core_sleep;
  rf_pkg::reg_addr_t             sleep_addrs [$];
  int unsigned                   cycle_count = 0;

  always #50 clk = ~clk;

  rf_top i_dut (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .fetch_enable_i ( fetch_enable ),
    .core_busy_i    ( core_busy    ),
    .debug_req_i    ( debug_req    ),
    .irq_pending_i  ( irq_pending  ),
    .irq_nm_i       ( irq_nm       ),
    .irq_fast_i     ( irq_fast     ),
    .we_i           ( we           ),
    .waddr_i        ( waddr        ),
    .wdata_i        ( wdata        ),
    .raddr_a_i      ( raddr_a      ),
    .rdata_a_o      ( rdata_a      ),
    .raddr_b_i      ( raddr_b      ),
    .rdata_b_o      ( rdata_b      ),
    .core_sleep_o   ( core_sleep   )
  );

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  task automatic clear_wake_sources();
    core_busy   = 1'b0;
    debug_req   = 1'b0;
    irq_pending = 1'b0;
    irq_nm      = 1'b0;
    irq_fast    = '0;
  endtask

  // Waits for the falling edge, then drives one random access
  task automatic drive_random_access(input logic write);
    @(negedge clk);
    we      = write;
    waddr   = rf_pkg::reg_addr_t'($urandom);
    wdata   = rf_pkg::reg_data_t'($urandom);
    raddr_a = rf_pkg::reg_addr_t'($urandom);
    raddr_b = (($urandom % 8) == 0) ? raddr_a : rf_pkg::reg_addr_t'($urandom);
  endtask

  // 0 busy, 1 debug, 2 irq_pending, 3 irq_nm, 4 and up one fast irq bit
  task automatic set_source(input int unsigned source);
    case (source)
      0: core_busy = 1'b1;
      1: debug_req = 1'b1;
      2: irq_pending = 1'b1;
      3: irq_nm = 1'b1;
      default: irq_fast = {{(rf_pkg::NumIrqFast-1){1'b0}}, 1'b1} << (source - 4);
    endcase
  endtask

  task automatic pulse_source(input int unsigned source, input int unsigned high_cycles);
    repeat (high_cycles) begin
      drive_random_access(1'b1);
      set_source(source);
    end
    drive_random_access(1'b1);
    clear_wake_sources();
  endtask

  task automatic sleep_writes(input int unsigned count);
    repeat (count) begin
      drive_random_access(1'b1);
      sleep_addrs.push_back(waddr);
    end
  endtask

  task automatic read_back();
    foreach (sleep_addrs[i]) begin
      @(negedge clk);
      we      = 1'b0;
      raddr_a = sleep_addrs[i];
      raddr_b = rf_pkg::reg_addr_t'($urandom);
    end
    sleep_addrs.delete();
  endtask

  //////////////////////////////////////////////////
  // Timeout and failure watch
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      $display("*** TEST FAILED ***");
      $fatal(1, "Run did not finish within %0d cycles", TimeoutCycles);
    end
  end

  always @(negedge clk) begin
    if (i_dut.u_assert.assert_failed) begin
      $display("*** TEST FAILED ***");
      $fatal(1, "A check in the bound checker failed");
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(7268));
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    we           = 1'b0;
    waddr        = '0;
    wdata        = '0;
    raddr_a      = '0;
    raddr_b      = '0;
    clear_wake_sources();
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Asleep before fetch enable, wake inputs random
    repeat (SleepWrites) begin
      drive_random_access(1'b1);
      sleep_addrs.push_back(waddr);
      core_busy   = 1'($urandom);
      debug_req   = 1'($urandom);
      irq_pending = 1'($urandom);
      irq_nm      = 1'($urandom);
      irq_fast    = rf_pkg::NumIrqFast'($urandom);
    end

    @(negedge clk);
    we = 1'b0;
    clear_wake_sources();
    fetch_enable = 1'b1;
    @(negedge clk);
    fetch_enable = 1'b0;

    // Fetch enabled but no wake source
    sleep_writes(SleepWrites);

    for (int unsigned s = 0; s < 4; s++) begin
      pulse_source(s, ScalarHigh);
    end
    for (int unsigned s = 4; s < 4 + rf_pkg::NumIrqFast; s++) begin
      pulse_source(s, FastHigh);
    end

    @(negedge clk);
    we        = 1'b0;
    core_busy = 1'b1;
    read_back();

    for (int i = 0; i < RandomCycles; i++) begin
      drive_random_access(1'b1);
      if ((i % 16) == 0) begin
        waddr = '0;
      end
    end

    // Late sleep, then wake again and read back
    @(negedge clk);
    we        = 1'b0;
    core_busy = 1'b0;
    @(negedge clk);
    sleep_writes(LateSleepWrites);
    @(negedge clk);
    we        = 1'b0;
    core_busy = 1'b1;
    read_back();

    @(negedge clk);
    if (i_dut.u_assert.assert_failed) begin
      $display("*** TEST FAILED ***");
      $fatal(1, "A check in the bound checker failed");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule
